// ==== design/tensor_pkg.sv ====
package tensor_pkg;

    // lanes mapped onto one octet, and lanes in an A or B half
    localparam int octet_lanes = 8;
    localparam int half_lanes  = 4;

    // D tile is 4x4, k dimension is 2
    localparam int tile_dim = 4;

    // warp id field inside queued entries, wide enough for up to 256 warps
    localparam int wid_bits = 8;

    typedef logic [31:0] word_t;

    typedef word_t [octet_lanes-1:0] lane_vec_t;

    typedef word_t [half_lanes-1:0] half_vec_t;

    // indexed [row][col]
    typedef word_t [tile_dim-1:0][tile_dim-1:0] tile_t;

    typedef logic [1:0] step_t;

    typedef logic [wid_bits-1:0] wid_t;

    // second instruction's halves come from the operand bus,
    // first instruction's halves come from the per-warp buffer
    typedef struct packed {
        half_vec_t a_second;
        half_vec_t b_second;
        lane_vec_t c_second;
        half_vec_t a_first;
        half_vec_t b_first;
        lane_vec_t c_first;
        wid_t      wid;
    } pair_entry_t;

    typedef struct packed {
        tile_t d;
        wid_t  wid;
    } result_entry_t;

endpackage

// ==== design/tensor_queue.sv ====
`timescale 1ns/1ps

module tensor_queue #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pointers wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/tensor_operand_collector.sv ====
`timescale 1ns/1ps

module tensor_operand_collector
    import tensor_pkg::*;
#(
    parameter int num_warps = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         operand_valid,
    input  logic [$clog2(num_warps)-1:0] operand_wid,
    input  step_t                        operand_step,
    input  logic                         operand_last,
    input  lane_vec_t                    operand_a,
    input  lane_vec_t                    operand_b,
    input  lane_vec_t                    operand_c,
    output logic                         operand_ready,
    input  logic                         queue_full,
    output logic                         push,
    output pair_entry_t                  entry
);

    localparam int wid_w = $clog2(num_warps);

    half_vec_t a_half;
    half_vec_t b_half;
    half_vec_t a_buf [num_warps];
    half_vec_t b_buf [num_warps];
    lane_vec_t c_buf [num_warps];
    logic      fire;
    logic      first_fire;

    // first-of-pair transfers are never queued, but they wait with the rest
    // so the bus sees a single ready
    assign operand_ready = !queue_full;
    assign fire          = operand_valid && operand_ready;
    assign first_fire    = fire && !operand_last;
    assign push          = fire && operand_last;

    // each threadgroup reads a 2x2 subtile of A
    // B is shared by both threadgroups, C is taken whole
    always_comb begin
        if (operand_step[0]) begin
            a_half = {operand_a[7:6], operand_a[3:2]};
        end else begin
            a_half = {operand_a[5:4], operand_a[1:0]};
        end
        if (operand_step[1]) begin
            b_half = operand_b[7:4];
        end else begin
            b_half = operand_b[3:0];
        end
    end

    // per-warp holding registers for the first instruction of a pair
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                a_buf[w] <= '0;
                b_buf[w] <= '0;
                c_buf[w] <= '0;
            end
        end else if (first_fire) begin
            a_buf[operand_wid] <= a_half;
            b_buf[operand_wid] <= b_half;
            c_buf[operand_wid] <= operand_c;
        end
    end

    // buffered halves are read in the same cycle the last instruction lands
    always_comb begin
        entry.a_second = a_half;
        entry.b_second = b_half;
        entry.c_second = operand_c;
        entry.a_first  = a_buf[operand_wid];
        entry.b_first  = b_buf[operand_wid];
        entry.c_first  = c_buf[operand_wid];
        entry.wid      = wid_t'(operand_wid[wid_w-1:0]);
    end

endmodule

// ==== design/tensor_dpu.sv ====
`timescale 1ns/1ps

module tensor_dpu
    import tensor_pkg::*;
#(
    parameter int num_warps = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          queue_empty,
    output logic          pop,
    input  pair_entry_t   entry,
    input  logic          stall,
    output logic          result_valid,
    output result_entry_t result
);

    localparam int wid_w = $clog2(num_warps);

    // A is 4x2 [row][k], B is 2x4 [k][col]
    word_t [tile_dim-1:0][1:0] a_tile;
    word_t [1:0][tile_dim-1:0] b_tile;
    tile_t                     c_tile;

    logic                                s1_valid;
    word_t [tile_dim-1:0][tile_dim-1:0][1:0] s1_prod;
    tile_t                               s1_c;
    logic [wid_w-1:0]                    s1_wid;
    logic                                s2_valid;
    tile_t                               s2_d;
    logic [wid_w-1:0]                    s2_wid;

    assign pop = !queue_empty && !stall;

    always_comb begin
        int lo;
        for (int r = 0; r < tile_dim; r++) begin
            a_tile[r][0] = entry.a_first[r];
            a_tile[r][1] = entry.a_second[r];
            // rows 0,1 draw on lanes 0-3, rows 2,3 on lanes 4-7
            lo = (r < 2) ? r : r + 2;
            c_tile[r][0] = entry.c_first[lo];
            c_tile[r][1] = entry.c_second[lo];
            c_tile[r][2] = entry.c_first[lo + 2];
            c_tile[r][3] = entry.c_second[lo + 2];
        end
        b_tile[0] = entry.b_first;
        b_tile[1] = entry.b_second;
    end

    // both stages freeze together while the output queue is full
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= pop;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int r = 0; r < tile_dim; r++) begin
                for (int c = 0; c < tile_dim; c++) begin
                    for (int k = 0; k < 2; k++) begin
                        s1_prod[r][c][k] <= a_tile[r][k] * b_tile[k][c];
                    end
                    s2_d[r][c] <= s1_c[r][c] + s1_prod[r][c][0] + s1_prod[r][c][1];
                end
            end
            s1_c   <= c_tile;
            s1_wid <= entry.wid[wid_w-1:0];
            s2_wid <= s1_wid;
        end
    end

    assign result_valid = s2_valid;

    always_comb begin
        result.d   = s2_d;
        result.wid = wid_t'(s2_wid);
    end

endmodule

// ==== design/tensor_writeback.sv ====
`timescale 1ns/1ps

module tensor_writeback
    import tensor_pkg::*;
#(
    parameter int num_warps = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         queue_empty,
    input  result_entry_t                result,
    output logic                         pop,
    output logic                         commit_valid,
    input  logic                         commit_ready,
    output logic [$clog2(num_warps)-1:0] commit_wid,
    output lane_vec_t                    commit_data
);

    localparam int wid_w = $clog2(num_warps);

    logic beat;
    logic fire;

    assign commit_valid = !queue_empty;
    assign fire         = commit_valid && commit_ready;
    // the tile leaves the queue once both beats are accepted
    assign pop          = fire && beat;
    assign commit_wid   = result.wid[wid_w-1:0];

    // 16 results over 8 lanes, beat 0 takes columns 0 and 2, beat 1 columns 1 and 3
    always_comb begin
        int col;
        col = beat ? 1 : 0;
        for (int h = 0; h < 2; h++) begin
            commit_data[4*h + 0] = result.d[2*h][col];
            commit_data[4*h + 1] = result.d[2*h + 1][col];
            commit_data[4*h + 2] = result.d[2*h][col + 2];
            commit_data[4*h + 3] = result.d[2*h + 1][col + 2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (fire) begin
            beat <= !beat;
        end
    end

endmodule

// ==== design/tensor_octet.sv ====
`timescale 1ns/1ps

module tensor_octet
    import tensor_pkg::*;
#(
    parameter int num_warps   = 4,
    parameter int queue_depth = 4
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         operand_valid,
    input  logic [$clog2(num_warps)-1:0] operand_wid,
    input  step_t                        operand_step,
    input  logic                         operand_last,
    input  lane_vec_t                    operand_a,
    input  lane_vec_t                    operand_b,
    input  lane_vec_t                    operand_c,
    output logic                         operand_ready,

    output logic                         commit_valid,
    output logic [$clog2(num_warps)-1:0] commit_wid,
    output lane_vec_t                    commit_data,
    input  logic                         commit_ready
);

    // input queue between collector and dot-product unit
    logic          in_push;
    logic          in_pop;
    logic          in_empty;
    logic          in_full;
    pair_entry_t   in_entry;
    pair_entry_t   in_head;

    // output queue between dot-product unit and writeback
    logic          out_push;
    logic          out_pop;
    logic          out_empty;
    logic          out_full;
    result_entry_t out_entry;
    result_entry_t out_head;

    tensor_operand_collector #(
        .num_warps (num_warps)
    ) collector (
        .clk           (clk),
        .reset         (reset),
        .operand_valid (operand_valid),
        .operand_wid   (operand_wid),
        .operand_step  (operand_step),
        .operand_last  (operand_last),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .operand_c     (operand_c),
        .operand_ready (operand_ready),
        .queue_full    (in_full),
        .push          (in_push),
        .entry         (in_entry)
    );

    tensor_queue #(
        .payload_t (pair_entry_t),
        .depth     (queue_depth)
    ) input_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (in_push),
        .pop      (in_pop),
        .data_in  (in_entry),
        .data_out (in_head),
        .empty    (in_empty),
        .full     (in_full)
    );

    // a full output queue freezes the pipeline, so its push is never dropped
    tensor_dpu #(
        .num_warps (num_warps)
    ) dpu (
        .clk          (clk),
        .reset        (reset),
        .queue_empty  (in_empty),
        .pop          (in_pop),
        .entry        (in_head),
        .stall        (out_full),
        .result_valid (out_push),
        .result       (out_entry)
    );

    tensor_queue #(
        .payload_t (result_entry_t),
        .depth     (queue_depth)
    ) output_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (out_push),
        .pop      (out_pop),
        .data_in  (out_entry),
        .data_out (out_head),
        .empty    (out_empty),
        .full     (out_full)
    );

    tensor_writeback #(
        .num_warps (num_warps)
    ) writeback (
        .clk          (clk),
        .reset        (reset),
        .queue_empty  (out_empty),
        .result       (out_head),
        .pop          (out_pop),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_wid   (commit_wid),
        .commit_data  (commit_data)
    );

endmodule

// ==== verification/tensor_tb_model.svh ====
`ifndef TENSOR_TB_MODEL_SVH
`define TENSOR_TB_MODEL_SVH

// expected beats in commit order, data and warp id kept side by side
lane_vec_t        exp_data_q [$];
logic [wid_w-1:0] exp_wid_q  [$];

// first-of-pair operands per warp, as they appeared on the bus
lane_vec_t held_a    [num_warps];
lane_vec_t held_b    [num_warps];
lane_vec_t held_c    [num_warps];
step_t     held_step [num_warps];

// A half is lanes 0,1,4,5 on even steps and 2,3,6,7 on odd steps
function automatic half_vec_t a_half_for(input step_t step, input lane_vec_t a);
    half_vec_t h;
    int        base;
    base = step[0] ? 2 : 0;
    h[0] = a[base];
    h[1] = a[base + 1];
    h[2] = a[base + 4];
    h[3] = a[base + 5];
    return h;
endfunction

// B half is lanes 0-3 for steps 0,1 and lanes 4-7 for steps 2,3
function automatic half_vec_t b_half_for(input step_t step, input lane_vec_t b);
    half_vec_t h;
    int        base;
    base = step[1] ? 4 : 0;
    for (int i = 0; i < half_lanes; i++) begin
        h[i] = b[base + i];
    end
    return h;
endfunction

function automatic tile_t expected_tile(input step_t first_step, input lane_vec_t first_a,
                                        input lane_vec_t first_b, input lane_vec_t first_c,
                                        input step_t second_step, input lane_vec_t second_a,
                                        input lane_vec_t second_b, input lane_vec_t second_c);
    tile_t     d;
    half_vec_t fa;
    half_vec_t fb;
    half_vec_t sa;
    half_vec_t sb;
    word_t     c_val;
    int        lo;
    fa = a_half_for(first_step, first_a);
    fb = b_half_for(first_step, first_b);
    sa = a_half_for(second_step, second_a);
    sb = b_half_for(second_step, second_b);
    for (int r = 0; r < 4; r++) begin
        // rows 0,1 use lanes r and r+2, rows 2,3 the upper four lanes
        lo = (r < 2) ? r : r + 2;
        for (int c = 0; c < 4; c++) begin
            case (c)
                0:       c_val = first_c[lo];
                1:       c_val = second_c[lo];
                2:       c_val = first_c[lo + 2];
                default: c_val = second_c[lo + 2];
            endcase
            // 32-bit target, so the sum wraps modulo 2^32
            d[r][c] = c_val + fa[r] * fb[c] + sa[r] * sb[c];
        end
    end
    return d;
endfunction

function automatic lane_vec_t beat_lanes(input tile_t d, input int beat);
    lane_vec_t v;
    v[0] = d[0][beat];
    v[1] = d[1][beat];
    v[2] = d[0][beat + 2];
    v[3] = d[1][beat + 2];
    v[4] = d[2][beat];
    v[5] = d[3][beat];
    v[6] = d[2][beat + 2];
    v[7] = d[3][beat + 2];
    return v;
endfunction

// called once per accepted operand transfer
task automatic model_accept(input logic [wid_w-1:0] wid, input step_t step, input logic last,
                            input lane_vec_t a, input lane_vec_t b, input lane_vec_t c);
    tile_t d;
    if (!last) begin
        held_a[wid]    = a;
        held_b[wid]    = b;
        held_c[wid]    = c;
        held_step[wid] = step;
    end else begin
        d = expected_tile(held_step[wid], held_a[wid], held_b[wid], held_c[wid],
                          step, a, b, c);
        exp_data_q.push_back(beat_lanes(d, 0));
        exp_wid_q.push_back(wid);
        exp_data_q.push_back(beat_lanes(d, 1));
        exp_wid_q.push_back(wid);
    end
endtask

`endif

// ==== verification/tensor_octet_tb.sv ====
`timescale 1ns/1ps

module tensor_octet_tb
    import tensor_pkg::*;
();

    localparam int num_warps      = 4;
    localparam int queue_depth    = 4;
    localparam int wid_w          = $clog2(num_warps);
    localparam int clk_period     = 8;
    localparam int timeout_cycles = 4000;

    logic             clk = 1'b0;
    logic             reset;
    logic             operand_valid;
    logic [wid_w-1:0] operand_wid;
    step_t            operand_step;
    logic             operand_last;
    lane_vec_t        operand_a;
    lane_vec_t        operand_b;
    lane_vec_t        operand_c;
    logic             operand_ready;
    logic             commit_valid;
    logic [wid_w-1:0] commit_wid;
    lane_vec_t        commit_data;
    logic             commit_ready;

    integer seed;
    int     cycle_count  = 0;
    int     error_count  = 0;
    int     beats_seen   = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    bit     send_done;

    `include "tensor_tb_model.svh"

    tensor_octet #(
        .num_warps   (num_warps),
        .queue_depth (queue_depth)
    ) tensor_octet_i (
        .clk           (clk),
        .reset         (reset),
        .operand_valid (operand_valid),
        .operand_wid   (operand_wid),
        .operand_step  (operand_step),
        .operand_last  (operand_last),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .operand_c     (operand_c),
        .operand_ready (operand_ready),
        .commit_valid  (commit_valid),
        .commit_wid    (commit_wid),
        .commit_data   (commit_data),
        .commit_ready  (commit_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("[%0t] timeout after %0d cycles, the tests did not finish", $time, cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

    // every accepted beat is compared with the oldest expected beat
    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            check_beat();
        end
    end

    task automatic check_beat();
        lane_vec_t        exp_data;
        logic [wid_w-1:0] exp_wid;
        beats_seen++;
        if (exp_data_q.size() == 0) begin
            $display("[%0t] commit beat accepted with no result expected", $time);
            error_count++;
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_wid  = exp_wid_q.pop_front();
            if (commit_wid !== exp_wid) begin
                $display("Mismatch at %0t: commit_wid expected %0d actual %0d",
                         $time, exp_wid, commit_wid);
                error_count++;
            end
            if (commit_data !== exp_data) begin
                $display("Mismatch at %0t: commit_data expected %h actual %h",
                         $time, exp_data, commit_data);
                error_count++;
            end
        end
    endtask

    function automatic lane_vec_t random_lanes(input bit big);
        lane_vec_t v;
        for (int l = 0; l < octet_lanes; l++) begin
            v[l] = $random(seed);
            // big values sit just under 2^32
            if (big) begin
                v[l] = v[l] | 32'hffff_0000;
            end
        end
        return v;
    endfunction

    // called and returns 1 ns after a rising edge
    task automatic send_op(input logic [wid_w-1:0] wid, input step_t step, input logic last,
                           input lane_vec_t a, input lane_vec_t b, input lane_vec_t c);
        operand_valid = 1'b1;
        operand_wid   = wid;
        operand_step  = step;
        operand_last  = last;
        operand_a     = a;
        operand_b     = b;
        operand_c     = c;
        @(posedge clk);
        while (!operand_ready) begin
            @(posedge clk);
        end
        model_accept(wid, step, last, a, b, c);
        #1;
        operand_valid = 1'b0;
        operand_last  = 1'b0;
    endtask

    task automatic send_pair(input logic [wid_w-1:0] wid, input step_t s1, input step_t s2,
                             input bit big);
        lane_vec_t a;
        lane_vec_t b;
        lane_vec_t c;
        for (int i = 0; i < 2; i++) begin
            a = random_lanes(big);
            b = random_lanes(big);
            c = random_lanes(big);
            send_op(wid, (i == 0) ? s1 : s2, i == 1, a, b, c);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_data_q.size() != 0 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_data_q.size() != 0) begin
            $display("[%0t] %0d expected beats never arrived", $time, exp_data_q.size());
            error_count++;
            exp_data_q.delete();
            exp_wid_q.delete();
        end
    endtask

    task automatic check_beat_count(input int beats_before, input int expected);
        if (beats_seen - beats_before != expected) begin
            $display("[%0t] %0d beats committed where %0d were expected",
                     $time, beats_seen - beats_before, expected);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: fail with %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        if (commit_valid !== 1'b0) begin
            $display("Mismatch at %0t: commit_valid expected 0 actual %b", $time, commit_valid);
            error_count++;
        end
        if (operand_ready !== 1'b1) begin
            $display("Mismatch at %0t: operand_ready expected 1 actual %b", $time, operand_ready);
            error_count++;
        end
        end_test("reset state", errors_before);
    endtask

    task automatic single_pair_steps();
        int errors_before;
        int beats_before;
        int wait_n;
        errors_before = error_count;
        commit_ready  = 1'b1;
        for (int s = 0; s < 4; s++) begin
            beats_before = beats_seen;
            send_pair('0, step_t'(s), step_t'(s), 1'b0);
            wait_n = 0;
            while (!commit_valid && wait_n < 50) begin
                @(posedge clk);
                #1;
                wait_n++;
            end
            if (wait_n < 3) begin
                $display("[%0t] step %0d result came %0d cycles after the last transfer",
                         $time, s, wait_n);
                error_count++;
            end
            wait_drain(50);
            check_beat_count(beats_before, 2);
        end
        end_test("single pair per step", errors_before);
    endtask

    task automatic interleaved_warps();
        int        errors_before;
        int        beats_before;
        int        order [4] = '{2, 0, 3, 1};
        lane_vec_t a;
        lane_vec_t b;
        lane_vec_t c;
        errors_before = error_count;
        beats_before  = beats_seen;
        for (int w = 0; w < num_warps; w++) begin
            a = random_lanes(1'b0);
            b = random_lanes(1'b0);
            c = random_lanes(1'b0);
            send_op(wid_w'(w), step_t'(w), 1'b0, a, b, c);
        end
        for (int i = 0; i < num_warps; i++) begin
            a = random_lanes(1'b0);
            b = random_lanes(1'b0);
            c = random_lanes(1'b0);
            send_op(wid_w'(order[i]), step_t'(3 - i), 1'b1, a, b, c);
        end
        wait_drain(100);
        check_beat_count(beats_before, 8);
        end_test("interleaved warps", errors_before);
    endtask

    task automatic back_pressure();
        int errors_before;
        int beats_before;
        int n;
        errors_before = error_count;
        beats_before  = beats_seen;
        commit_ready  = 1'b0;
        send_done     = 1'b0;
        fork
            begin
                for (int p = 0; p < 12; p++) begin
                    send_pair(wid_w'(p), step_t'(p), step_t'(p + 1), 1'b0);
                end
                send_done = 1'b1;
            end
            begin
                n = 0;
                while (operand_ready && n < 100) begin
                    @(posedge clk);
                    #1;
                    n++;
                end
                if (operand_ready) begin
                    $display("[%0t] operand_ready stayed high with commits held back", $time);
                    error_count++;
                end
                repeat (5) @(posedge clk);
                #1;
                if (commit_valid !== 1'b1) begin
                    $display("Mismatch at %0t: commit_valid expected 1 actual %b",
                             $time, commit_valid);
                    error_count++;
                end
                // release with random gaps until every pair is sent and committed
                n = 0;
                while ((exp_data_q.size() != 0 || !send_done) && n < 500) begin
                    commit_ready = (($random(seed) & 3) != 0);
                    @(posedge clk);
                    #1;
                    n++;
                end
                commit_ready = 1'b1;
                if (n >= 500) begin
                    $display("[%0t] results did not drain after commit_ready was released",
                             $time);
                    error_count++;
                end
            end
        join
        wait_drain(50);
        check_beat_count(beats_before, 24);
        end_test("back-pressure", errors_before);
    endtask

    task automatic wrapping_arithmetic();
        int errors_before;
        int beats_before;
        errors_before = error_count;
        beats_before  = beats_seen;
        commit_ready  = 1'b1;
        for (int p = 0; p < 4; p++) begin
            send_pair(wid_w'(p), step_t'(p), step_t'(3 - p), 1'b1);
        end
        wait_drain(100);
        check_beat_count(beats_before, 8);
        end_test("wrapping arithmetic", errors_before);
    endtask

    initial begin
        seed          = 43;
        reset         = 1'b1;
        operand_valid = 1'b0;
        operand_wid   = '0;
        operand_step  = '0;
        operand_last  = 1'b0;
        operand_a     = '0;
        operand_b     = '0;
        operand_c     = '0;
        commit_ready  = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_state();
        single_pair_steps();
        interleaved_warps();
        back_pressure();
        wrapping_arithmetic();

        // a few idle cycles so a stray beat would still be caught
        repeat (5) @(posedge clk);
        $display("tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, beats_seen, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verification
design/tensor_pkg.sv
design/tensor_queue.sv
design/tensor_operand_collector.sv
design/tensor_dpu.sv
design/tensor_writeback.sv
design/tensor_octet.sv
verification/tensor_octet_tb.sv
